//--- surf_ctrl_pkg.sv
package surf_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths and identity words
    ////////////////////////////////////////////////////////////

    localparam int DATA_W = 32;
    localparam int ADDR_W = 16;

    // ASCII "S5A7"
    localparam logic [DATA_W-1:0] DEVICE_ID   = 32'h5335_4137;
    localparam logic [DATA_W-1:0] FIRMWARE_ID = 32'h0001_0203;

    // Interrupt status bit 0 is the SPI master, the rest are external
    localparam int NUM_EXT_IRQ = 31;
    localparam int NUM_LED     = 12;
    localparam int LED_PINS    = 4;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    localparam logic [ADDR_W-1:0] ADDR_ID       = 16'h0000;
    localparam logic [ADDR_W-1:0] ADDR_FW       = 16'h0004;
    localparam logic [ADDR_W-1:0] ADDR_INT_SR   = 16'h0008;
    localparam logic [ADDR_W-1:0] ADDR_INT_MASK = 16'h000C;
    localparam logic [ADDR_W-1:0] ADDR_RESET    = 16'h0014;
    localparam logic [ADDR_W-1:0] ADDR_LED      = 16'h0018;
    localparam logic [ADDR_W-1:0] ADDR_CLKSEL   = 16'h001C;
    localparam logic [ADDR_W-1:0] ADDR_SPISS    = 16'h0024;
    localparam logic [ADDR_W-1:0] ADDR_SPI_DATA = 16'h0030;
    localparam logic [ADDR_W-1:0] ADDR_SPI_STAT = 16'h0034;

    // LED register layout
    localparam int LED_VAL_LSB = 0;
    localparam int LED_FP_BIT  = 12;
    localparam int LED_OVR_LSB = 16;

    ////////////////////////////////////////////////////////////
    // SPI master and LED scanner
    ////////////////////////////////////////////////////////////

    // clk_i cycles per SCK half period
    localparam int SPI_CLK_DIV = 4;

    // Pin drive value per scan step, step 11 first
    // Steps 0-5 green, steps 6-11 red (inverted polarity)
    localparam logic [NUM_LED-1:0][LED_PINS-1:0] LED_OUT_TABLE = {
        4'b1110, 4'b1101, 4'b1011, 4'b1101, 4'b1110, 4'b1110,
        4'b0001, 4'b0010, 4'b0100, 4'b0010, 4'b0001, 4'b0001
    };

    // Active-low pin enables per scan step, step 11 first
    // Pairs 0-1, 0-2, 1-2, 2-3, 1-3, 0-3 for each colour
    localparam logic [NUM_LED-1:0][LED_PINS-1:0] LED_OEN_TABLE = {
        4'b0110, 4'b0101, 4'b0011, 4'b1001, 4'b1010, 4'b1100,
        4'b0110, 4'b0101, 4'b0011, 4'b1001, 4'b1010, 4'b1100
    };

endpackage

//--- surf_ctrl_regs.sv
`timescale 1ns/10ps

module surf_ctrl_regs (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    // APB slave
    input  logic                                 psel_i,
    input  logic                                 penable_i,
    input  logic                                 pwrite_i,
    input  logic [surf_ctrl_pkg::ADDR_W-1:0]     paddr_i,
    input  logic [surf_ctrl_pkg::DATA_W-1:0]     pwdata_i,
    output logic [surf_ctrl_pkg::DATA_W-1:0]     prdata_o,
    output logic                                 pready_o,
    output logic                                 pslverr_o,
    // Interrupt sources
    input  logic [surf_ctrl_pkg::NUM_EXT_IRQ-1:0] irq_i,
    input  logic [surf_ctrl_pkg::NUM_LED-1:0]     internal_led_i,
    // SPI master side
    input  logic                                 spi_busy_i,
    input  logic                                 spi_done_i,
    input  logic [7:0]                           spi_rx_byte_i,
    // Board controls
    output logic                                 irq_o,
    output logic                                 global_reset_o,
    output logic                                 sst_sel_o,
    output logic                                 sst_sel_oe_o,
    output logic                                 local_osc_en_o,
    output logic                                 fp_led_o,
    output logic                                 spi_cs_b_o,
    output logic                                 spi_start_o,
    output logic [7:0]                           spi_tx_byte_o,
    output logic [surf_ctrl_pkg::NUM_LED-1:0]     led_val_o
);

    ////////////////////////////////////////////////////////////
    // Register storage
    ////////////////////////////////////////////////////////////

    logic [surf_ctrl_pkg::DATA_W-1:0] int_sr_reg;
    logic [surf_ctrl_pkg::DATA_W-1:0] int_mask_reg;
    logic [surf_ctrl_pkg::DATA_W-1:0] reset_reg;
    logic [surf_ctrl_pkg::DATA_W-1:0] led_reg;
    logic [surf_ctrl_pkg::DATA_W-1:0] clksel_reg;
    logic [surf_ctrl_pkg::DATA_W-1:0] spiss_reg;

    // Access cycle write qualifier
    logic wr_en;
    logic [surf_ctrl_pkg::DATA_W-1:0] rd_data;
    logic addr_hit;

    // Interrupt update terms
    logic [surf_ctrl_pkg::DATA_W-1:0] int_clr;
    logic [surf_ctrl_pkg::DATA_W-1:0] int_src;

    // LED override masks, stored and on the bus
    logic [surf_ctrl_pkg::NUM_LED-1:0] led_ovr_wr;
    logic [surf_ctrl_pkg::NUM_LED-1:0] led_ovr_cur;

    ////////////////////////////////////////////////////////////
    // APB decode
    ////////////////////////////////////////////////////////////

    // No wait states
    assign pready_o = 1'b1;
    assign wr_en    = psel_i & penable_i & pwrite_i;

    // Read mux and address check
    always_comb begin
        addr_hit = 1'b1;
        case (paddr_i)
            surf_ctrl_pkg::ADDR_ID:       rd_data = surf_ctrl_pkg::DEVICE_ID;
            surf_ctrl_pkg::ADDR_FW:       rd_data = surf_ctrl_pkg::FIRMWARE_ID;
            surf_ctrl_pkg::ADDR_INT_SR:   rd_data = int_sr_reg;
            surf_ctrl_pkg::ADDR_INT_MASK: rd_data = int_mask_reg;
            surf_ctrl_pkg::ADDR_RESET:    rd_data = reset_reg;
            surf_ctrl_pkg::ADDR_LED:      rd_data = led_reg;
            surf_ctrl_pkg::ADDR_CLKSEL:   rd_data = clksel_reg;
            surf_ctrl_pkg::ADDR_SPISS:    rd_data = spiss_reg;
            surf_ctrl_pkg::ADDR_SPI_DATA: rd_data = {24'h0, spi_rx_byte_i};
            // Busy in bit 0, last received byte in 15:8
            surf_ctrl_pkg::ADDR_SPI_STAT: rd_data = {16'h0, spi_rx_byte_i, 7'h0, spi_busy_i};
            default: begin
                rd_data  = '0;
                addr_hit = 1'b0;
            end
        endcase
    end

    assign prdata_o  = rd_data;
    assign pslverr_o = psel_i & penable_i & ~addr_hit;

    ////////////////////////////////////////////////////////////
    // Plain read/write registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            int_mask_reg <= '0;
            reset_reg    <= '0;
            clksel_reg   <= '0;
            spiss_reg    <= '0;
        end else if (wr_en) begin
            if (paddr_i == surf_ctrl_pkg::ADDR_INT_MASK) begin
                int_mask_reg <= pwdata_i;
            end
            if (paddr_i == surf_ctrl_pkg::ADDR_RESET) begin
                reset_reg <= pwdata_i;
            end
            if (paddr_i == surf_ctrl_pkg::ADDR_CLKSEL) begin
                clksel_reg <= pwdata_i;
            end
            if (paddr_i == surf_ctrl_pkg::ADDR_SPISS) begin
                spiss_reg <= pwdata_i;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Interrupt status, write 1 to clear
    ////////////////////////////////////////////////////////////

    assign int_clr = (wr_en && paddr_i == surf_ctrl_pkg::ADDR_INT_SR) ? pwdata_i : '0;
    // Bit 0 from the SPI master
    assign int_src = {irq_i, spi_done_i};

    // A source held high wins over a clear in the same cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            int_sr_reg <= '0;
        end else begin
            int_sr_reg <= (int_sr_reg & ~int_clr) | int_src;
        end
    end

    // Mask bit set means masked
    assign irq_o = |(int_sr_reg & ~int_mask_reg);

    ////////////////////////////////////////////////////////////
    // LED register
    ////////////////////////////////////////////////////////////

    assign led_ovr_wr  = pwdata_i[surf_ctrl_pkg::LED_OVR_LSB +: surf_ctrl_pkg::NUM_LED];
    assign led_ovr_cur = led_reg[surf_ctrl_pkg::LED_OVR_LSB +: surf_ctrl_pkg::NUM_LED];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            led_reg <= '0;
        end else if (wr_en && paddr_i == surf_ctrl_pkg::ADDR_LED) begin
            // Upper fields as written
            led_reg[surf_ctrl_pkg::DATA_W-1:surf_ctrl_pkg::NUM_LED] <=
                pwdata_i[surf_ctrl_pkg::DATA_W-1:surf_ctrl_pkg::NUM_LED];
            // Written value where overridden, live LEDs elsewhere
            led_reg[surf_ctrl_pkg::LED_VAL_LSB +: surf_ctrl_pkg::NUM_LED] <=
                (pwdata_i[surf_ctrl_pkg::LED_VAL_LSB +: surf_ctrl_pkg::NUM_LED] & led_ovr_wr) |
                (internal_led_i & ~led_ovr_wr);
        end else begin
            // Sticky internal events under the stored mask
            led_reg[surf_ctrl_pkg::LED_VAL_LSB +: surf_ctrl_pkg::NUM_LED] <=
                led_reg[surf_ctrl_pkg::LED_VAL_LSB +: surf_ctrl_pkg::NUM_LED] |
                (internal_led_i & ~led_ovr_cur);
        end
    end

    assign led_val_o = led_reg[surf_ctrl_pkg::LED_VAL_LSB +: surf_ctrl_pkg::NUM_LED];
    assign fp_led_o  = led_reg[surf_ctrl_pkg::LED_FP_BIT];

    ////////////////////////////////////////////////////////////
    // Board control outputs
    ////////////////////////////////////////////////////////////

    assign global_reset_o = reset_reg[0];
    assign sst_sel_o      = clksel_reg[0];
    assign sst_sel_oe_o   = clksel_reg[1];
    assign local_osc_en_o = clksel_reg[2];

    // Slave select bit is active high in the register
    assign spi_cs_b_o = ~spiss_reg[0];

    // Start only when idle, data write while busy is dropped
    assign spi_start_o   = wr_en & (paddr_i == surf_ctrl_pkg::ADDR_SPI_DATA) & ~spi_busy_i;
    assign spi_tx_byte_o = pwdata_i[7:0];

endmodule

//--- surf_ctrl_spi_master.sv
`timescale 1ns/10ps

module surf_ctrl_spi_master (
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       spi_start_i,
    input  logic [7:0] spi_tx_byte_i,
    input  logic       spi_miso_i,
    output logic       spi_busy_o,
    output logic       spi_done_o,
    output logic [7:0] spi_rx_byte_o,
    output logic       spi_sck_o,
    output logic       spi_mosi_o
);

    // Half-period divider
    logic [$clog2(surf_ctrl_pkg::SPI_CLK_DIV)-1:0] div_cnt;
    // Bits finished so far
    logic [2:0] bit_cnt;
    logic       busy;
    logic       done;
    logic       sck;
    logic [7:0] tx_shift;
    logic [7:0] rx_shift;
    logic [7:0] rx_byte;
    logic       half_end;

    assign half_end = (int'(div_cnt) == surf_ctrl_pkg::SPI_CLK_DIV - 1);

    ////////////////////////////////////////////////////////////
    // Control and clock generation
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy     <= 1'b0;
            done     <= 1'b0;
            sck      <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            tx_shift <= '0;
            rx_byte  <= '0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                if (spi_start_i) begin
                    // MSB goes out before the first rising edge
                    busy     <= 1'b1;
                    sck      <= 1'b0;
                    div_cnt  <= '0;
                    bit_cnt  <= '0;
                    tx_shift <= spi_tx_byte_i;
                end
            end else if (half_end) begin
                div_cnt <= '0;
                sck     <= ~sck;
                if (sck) begin
                    // Falling edge, next bit onto MOSI
                    tx_shift <= {tx_shift[6:0], 1'b0};
                    bit_cnt  <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) begin
                        busy    <= 1'b0;
                        done    <= 1'b1;
                        rx_byte <= rx_shift;
                    end
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Mode 0 sample on the rising SCK edge
    always_ff @(posedge clk_i) begin
        if (busy && half_end && !sck) begin
            rx_shift <= {rx_shift[6:0], spi_miso_i};
        end
    end

    assign spi_busy_o    = busy;
    assign spi_done_o    = done;
    assign spi_rx_byte_o = rx_byte;
    assign spi_sck_o     = sck;
    assign spi_mosi_o    = tx_shift[7];

endmodule

//--- surf_ctrl_led_charlie.sv
`timescale 1ns/10ps

module surf_ctrl_led_charlie (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic [surf_ctrl_pkg::NUM_LED-1:0]   led_val_i,
    output logic [surf_ctrl_pkg::LED_PINS-1:0]  led_out_o,
    output logic [surf_ctrl_pkg::LED_PINS-1:0]  led_oen_o
);

    // Current scan step, 0 to NUM_LED-1
    logic [$clog2(surf_ctrl_pkg::NUM_LED)-1:0] step;
    logic [surf_ctrl_pkg::LED_PINS-1:0]        led_out;
    logic [surf_ctrl_pkg::LED_PINS-1:0]        led_oen;

    ////////////////////////////////////////////////////////////
    // Step counter
    ////////////////////////////////////////////////////////////

    // Wraps after the last LED so every step is visited
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            step <= '0;
        end else if (int'(step) == surf_ctrl_pkg::NUM_LED - 1) begin
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pin drive
    ////////////////////////////////////////////////////////////

    // Lit LED gets its pin pair, dark LED floats all pins
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            led_out <= '0;
            led_oen <= '1;
        end else if (led_val_i[step]) begin
            led_out <= surf_ctrl_pkg::LED_OUT_TABLE[step];
            led_oen <= surf_ctrl_pkg::LED_OEN_TABLE[step];
        end else begin
            // Drive value is don't-care while disabled
            led_oen <= '1;
        end
    end

    assign led_out_o = led_out;
    assign led_oen_o = led_oen;

endmodule

//--- surf_ctrl_top.sv
`timescale 1ns/10ps

module surf_ctrl_top (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    // APB slave
    input  logic                                  psel_i,
    input  logic                                  penable_i,
    input  logic                                  pwrite_i,
    input  logic [surf_ctrl_pkg::ADDR_W-1:0]      paddr_i,
    input  logic [surf_ctrl_pkg::DATA_W-1:0]      pwdata_i,
    output logic [surf_ctrl_pkg::DATA_W-1:0]      prdata_o,
    output logic                                  pready_o,
    output logic                                  pslverr_o,
    // Sources
    input  logic [surf_ctrl_pkg::NUM_EXT_IRQ-1:0] irq_i,
    input  logic [surf_ctrl_pkg::NUM_LED-1:0]     internal_led_i,
    input  logic                                  spi_miso_i,
    // Board outputs
    output logic                                  irq_o,
    output logic                                  global_reset_o,
    output logic                                  sst_sel_o,
    output logic                                  sst_sel_oe_o,
    output logic                                  local_osc_en_o,
    output logic                                  fp_led_o,
    output logic [surf_ctrl_pkg::LED_PINS-1:0]    led_out_o,
    output logic [surf_ctrl_pkg::LED_PINS-1:0]    led_oen_o,
    output logic                                  spi_sck_o,
    output logic                                  spi_mosi_o,
    output logic                                  spi_cs_b_o
);

    // Regs to SPI master
    logic       spi_start;
    logic [7:0] spi_tx_byte;
    // SPI master back to regs
    logic       spi_busy;
    logic       spi_done;
    logic [7:0] spi_rx_byte;
    // Regs to LED scanner
    logic [surf_ctrl_pkg::NUM_LED-1:0] led_val;

    surf_ctrl_regs u_regs (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .irq_i          (irq_i),
        .internal_led_i (internal_led_i),
        .spi_busy_i     (spi_busy),
        .spi_done_i     (spi_done),
        .spi_rx_byte_i  (spi_rx_byte),
        .irq_o          (irq_o),
        .global_reset_o (global_reset_o),
        .sst_sel_o      (sst_sel_o),
        .sst_sel_oe_o   (sst_sel_oe_o),
        .local_osc_en_o (local_osc_en_o),
        .fp_led_o       (fp_led_o),
        .spi_cs_b_o     (spi_cs_b_o),
        .spi_start_o    (spi_start),
        .spi_tx_byte_o  (spi_tx_byte),
        .led_val_o      (led_val)
    );

    surf_ctrl_spi_master u_spi (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .spi_start_i   (spi_start),
        .spi_tx_byte_i (spi_tx_byte),
        .spi_miso_i    (spi_miso_i),
        .spi_busy_o    (spi_busy),
        .spi_done_o    (spi_done),
        .spi_rx_byte_o (spi_rx_byte),
        .spi_sck_o     (spi_sck_o),
        .spi_mosi_o    (spi_mosi_o)
    );

    surf_ctrl_led_charlie u_led (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .led_val_i (led_val),
        .led_out_o (led_out_o),
        .led_oen_o (led_oen_o)
    );

endmodule

//--- tb_surf_ctrl.sv
`timescale 1ns/10ps

module tb_surf_ctrl;

    localparam int CLK_PERIOD = 100;
    // Status reads allowed before a stuck transfer is reported
    localparam int SPI_POLL_MAX = 16 * surf_ctrl_pkg::SPI_CLK_DIV;
    // Two full scan rounds
    localparam int LED_WAIT_MAX = 2 * surf_ctrl_pkg::NUM_LED;

    logic                                  clk_i;
    logic                                  rst_i;
    logic                                  psel_i;
    logic                                  penable_i;
    logic                                  pwrite_i;
    logic [surf_ctrl_pkg::ADDR_W-1:0]      paddr_i;
    logic [surf_ctrl_pkg::DATA_W-1:0]      pwdata_i;
    logic [surf_ctrl_pkg::DATA_W-1:0]      prdata_o;
    logic                                  pready_o;
    logic                                  pslverr_o;
    logic [surf_ctrl_pkg::NUM_EXT_IRQ-1:0] irq_i;
    logic [surf_ctrl_pkg::NUM_LED-1:0]     internal_led_i;
    logic                                  spi_miso_i;
    logic                                  irq_o;
    logic                                  global_reset_o;
    logic                                  sst_sel_o;
    logic                                  sst_sel_oe_o;
    logic                                  local_osc_en_o;
    logic                                  fp_led_o;
    logic [surf_ctrl_pkg::LED_PINS-1:0]    led_out_o;
    logic [surf_ctrl_pkg::LED_PINS-1:0]    led_oen_o;
    logic                                  spi_sck_o;
    logic                                  spi_mosi_o;
    logic                                  spi_cs_b_o;

    integer seed;
    string  cur_test;
    int     test_errors;
    int     tests_passed;
    int     tests_failed;

    // SPI loopback
    assign spi_miso_i = spi_mosi_o;

    surf_ctrl_top u_dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .irq_i          (irq_i),
        .internal_led_i (internal_led_i),
        .spi_miso_i     (spi_miso_i),
        .irq_o          (irq_o),
        .global_reset_o (global_reset_o),
        .sst_sel_o      (sst_sel_o),
        .sst_sel_oe_o   (sst_sel_oe_o),
        .local_osc_en_o (local_osc_en_o),
        .fp_led_o       (fp_led_o),
        .led_out_o      (led_out_o),
        .led_oen_o      (led_oen_o),
        .spi_sck_o      (spi_sck_o),
        .spi_mosi_o     (spi_mosi_o),
        .spi_cs_b_o     (spi_cs_b_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////
    // Bookkeeping and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("PASS %s", cur_test);
            tests_passed = tests_passed + 1;
        end else begin
            $display("FAIL %s with %0d errors", cur_test, test_errors);
            tests_failed = tests_failed + 1;
        end
    endtask

    task automatic check_word(input string what,
                              input logic [surf_ctrl_pkg::DATA_W-1:0] exp,
                              input logic [surf_ctrl_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected 0x%08h actual 0x%08h", cur_test, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected %b actual %b", cur_test, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_nibble(input string what,
                                input logic [surf_ctrl_pkg::LED_PINS-1:0] exp,
                                input logic [surf_ctrl_pkg::LED_PINS-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s %s: expected 0x%h actual 0x%h", cur_test, what, exp, act);
            test_errors = test_errors + 1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB driver
    ////////////////////////////////////////////////////////////

    // Setup, access, then idle; write lands on the edge ending access
    task automatic apb_write(input logic [surf_ctrl_pkg::ADDR_W-1:0] addr,
                             input logic [surf_ctrl_pkg::DATA_W-1:0] data);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        @(negedge clk_i);
        penable_i = 1'b1;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input  logic [surf_ctrl_pkg::ADDR_W-1:0] addr,
                            output logic [surf_ctrl_pkg::DATA_W-1:0] data,
                            output logic                             slverr);
        @(negedge clk_i);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        @(negedge clk_i);
        penable_i = 1'b1;
        // Sample mid access phase, well away from both edges
        #(CLK_PERIOD / 4);
        check_bit("pready", 1'b1, pready_o);
        data   = prdata_o;
        slverr = pslverr_o;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    // Poll SPI status until busy clears
    task automatic wait_spi_idle();
        logic [surf_ctrl_pkg::DATA_W-1:0] stat;
        logic                             err;
        int                               polls;
        polls = 0;
        stat  = 32'h1;
        while (stat[0] === 1'b1 && polls < SPI_POLL_MAX) begin
            apb_read(surf_ctrl_pkg::ADDR_SPI_STAT, stat, err);
            polls = polls + 1;
        end
        if (stat[0] !== 1'b0) begin
            $display("%s: SPI master still busy after %0d status reads", cur_test, polls);
            test_errors = test_errors + 1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state();
        start_test("reset_state");
        check_bit("irq_o", 1'b0, irq_o);
        check_bit("global_reset_o", 1'b0, global_reset_o);
        check_bit("sst_sel_oe_o", 1'b0, sst_sel_oe_o);
        check_bit("local_osc_en_o", 1'b0, local_osc_en_o);
        check_bit("spi_cs_b_o", 1'b1, spi_cs_b_o);
        check_bit("spi_sck_o", 1'b0, spi_sck_o);
        check_nibble("led_oen_o", 4'hF, led_oen_o);
        finish_test();
    endtask

    task automatic id_and_unmapped();
        logic [surf_ctrl_pkg::DATA_W-1:0] rd;
        logic                             err;
        start_test("id_and_unmapped");
        apb_read(surf_ctrl_pkg::ADDR_ID, rd, err);
        check_word("device id", "S5A7", rd);
        check_bit("id slverr", 1'b0, err);
        apb_read(surf_ctrl_pkg::ADDR_FW, rd, err);
        check_word("firmware", 32'h0001_0203, rd);
        check_bit("fw slverr", 1'b0, err);
        // Hole in the map
        apb_read(16'h0040, rd, err);
        check_bit("unmapped slverr", 1'b1, err);
        finish_test();
    endtask

    task automatic register_readback();
        logic [surf_ctrl_pkg::DATA_W-1:0] val [4];
        logic [surf_ctrl_pkg::ADDR_W-1:0] addr [4];
        logic [surf_ctrl_pkg::DATA_W-1:0] rd;
        logic                             err;
        start_test("register_readback");
        addr[0] = surf_ctrl_pkg::ADDR_INT_MASK;
        addr[1] = surf_ctrl_pkg::ADDR_RESET;
        addr[2] = surf_ctrl_pkg::ADDR_CLKSEL;
        addr[3] = surf_ctrl_pkg::ADDR_SPISS;
        for (int i = 0; i < 4; i++) begin
            val[i] = $random(seed);
            apb_write(addr[i], val[i]);
        end
        for (int i = 0; i < 4; i++) begin
            apb_read(addr[i], rd, err);
            check_word($sformatf("readback 0x%02h", addr[i]), val[i], rd);
        end
        check_bit("global_reset_o", val[1][0], global_reset_o);
        check_bit("sst_sel_o", val[2][0], sst_sel_o);
        check_bit("sst_sel_oe_o", val[2][1], sst_sel_oe_o);
        check_bit("local_osc_en_o", val[2][2], local_osc_en_o);
        // Select bit is active high, pin active low
        check_bit("spi_cs_b_o", ~val[3][0], spi_cs_b_o);
        finish_test();
    endtask

    task automatic interrupt_flow();
        logic [surf_ctrl_pkg::DATA_W-1:0] rnd;
        logic [surf_ctrl_pkg::DATA_W-1:0] int_bit;
        logic [surf_ctrl_pkg::DATA_W-1:0] rd;
        logic [4:0]                       n;
        logic                             err;
        start_test("interrupt_flow");
        rnd     = $random(seed);
        n       = 5'(rnd % 32'd31);
        int_bit = 32'd1 << (n + 5'd1);
        // Everything masked first
        apb_write(surf_ctrl_pkg::ADDR_INT_MASK, 32'hFFFF_FFFF);
        @(negedge clk_i);
        irq_i[n] = 1'b1;
        @(negedge clk_i);
        irq_i = '0;
        apb_read(surf_ctrl_pkg::ADDR_INT_SR, rd, err);
        check_word("status after pulse", int_bit, rd);
        check_bit("irq_o masked", 1'b0, irq_o);
        apb_write(surf_ctrl_pkg::ADDR_INT_MASK, ~int_bit);
        check_bit("irq_o unmasked", 1'b1, irq_o);
        // Write one to clear
        apb_write(surf_ctrl_pkg::ADDR_INT_SR, int_bit);
        check_bit("irq_o cleared", 1'b0, irq_o);
        apb_read(surf_ctrl_pkg::ADDR_INT_SR, rd, err);
        check_word("status cleared", 32'h0, rd);
        finish_test();
    endtask

    task automatic led_register();
        logic [surf_ctrl_pkg::DATA_W-1:0]  rnd;
        logic [surf_ctrl_pkg::DATA_W-1:0]  rd;
        logic [surf_ctrl_pkg::NUM_LED-1:0] p;
        logic [surf_ctrl_pkg::NUM_LED-1:0] q;
        logic [surf_ctrl_pkg::NUM_LED-1:0] ovr;
        logic [surf_ctrl_pkg::NUM_LED-1:0] val;
        logic                              err;
        start_test("led_register");
        rnd = $random(seed);
        p   = rnd[11:0];
        ovr = rnd[27:16];
        rnd = $random(seed);
        val = rnd[11:0];
        q   = rnd[27:16];
        // No overrides stored yet, so the whole pulse sticks
        @(negedge clk_i);
        internal_led_i = p;
        @(negedge clk_i);
        internal_led_i = '0;
        apb_read(surf_ctrl_pkg::ADDR_LED, rd, err);
        check_word("sticky internal", {20'h0, p}, rd);
        apb_write(surf_ctrl_pkg::ADDR_LED, {4'h0, ovr, 3'h0, 1'b1, val});
        apb_read(surf_ctrl_pkg::ADDR_LED, rd, err);
        check_word("override write", {4'h0, ovr, 3'h0, 1'b1, val & ovr}, rd);
        check_bit("fp_led_o set", 1'b1, fp_led_o);
        // Internal events only where not overridden
        // Idle bus data carries the opposite override mask
        @(negedge clk_i);
        pwdata_i       = ~{4'h0, ovr, 16'h0};
        internal_led_i = q;
        @(negedge clk_i);
        internal_led_i = '0;
        apb_read(surf_ctrl_pkg::ADDR_LED, rd, err);
        check_word("masked sticky", {4'h0, ovr, 3'h0, 1'b1, (val & ovr) | (q & ~ovr)}, rd);
        apb_write(surf_ctrl_pkg::ADDR_LED, {4'h0, ovr, 16'h0});
        check_bit("fp_led_o clear", 1'b0, fp_led_o);
        finish_test();
    endtask

    task automatic led_scanner();
        logic [surf_ctrl_pkg::DATA_W-1:0]   rnd;
        logic [3:0]                         k;
        logic [surf_ctrl_pkg::LED_PINS-1:0] exp_oen;
        logic [surf_ctrl_pkg::LED_PINS-1:0] exp_out;
        logic                               found;
        start_test("led_scanner");
        rnd     = $random(seed);
        k       = 4'(rnd % 32'd12);
        exp_oen = surf_ctrl_pkg::LED_OEN_TABLE[k];
        exp_out = surf_ctrl_pkg::LED_OUT_TABLE[k];
        // Override all, light only LED k
        apb_write(surf_ctrl_pkg::ADDR_LED, {4'h0, 12'hFFF, 4'h0, 12'd1 << k});
        found = 1'b0;
        for (int i = 0; i < LED_WAIT_MAX && !found; i++) begin
            @(negedge clk_i);
            if (led_oen_o === exp_oen) begin
                found = 1'b1;
            end
        end
        check_nibble($sformatf("enables step %0d", k), exp_oen, led_oen_o);
        check_nibble($sformatf("drive step %0d", k), exp_out, led_out_o);
        // All dark, pins must stay released
        apb_write(surf_ctrl_pkg::ADDR_LED, {4'h0, 12'hFFF, 16'h0});
        @(negedge clk_i);
        for (int i = 0; i < LED_WAIT_MAX; i++) begin
            @(negedge clk_i);
            check_nibble("enables dark", 4'hF, led_oen_o);
        end
        finish_test();
    endtask

    task automatic spi_loopback();
        logic [surf_ctrl_pkg::DATA_W-1:0] rnd;
        logic [surf_ctrl_pkg::DATA_W-1:0] rd;
        logic [7:0]                       b;
        logic                             err;
        start_test("spi_loopback");
        rnd = $random(seed);
        b   = rnd[7:0];
        apb_write(surf_ctrl_pkg::ADDR_INT_SR, 32'h1);
        apb_write(surf_ctrl_pkg::ADDR_SPISS, 32'h1);
        check_bit("spi_cs_b_o selected", 1'b0, spi_cs_b_o);
        apb_write(surf_ctrl_pkg::ADDR_SPI_DATA, {24'h0, b});
        apb_read(surf_ctrl_pkg::ADDR_SPI_STAT, rd, err);
        check_bit("busy after start", 1'b1, rd[0]);
        wait_spi_idle();
        apb_read(surf_ctrl_pkg::ADDR_SPI_DATA, rd, err);
        check_word("rx data", {24'h0, b}, rd);
        apb_read(surf_ctrl_pkg::ADDR_SPI_STAT, rd, err);
        check_word("status", {16'h0, b, 8'h0}, rd);
        apb_read(surf_ctrl_pkg::ADDR_INT_SR, rd, err);
        check_bit("done interrupt", 1'b1, rd[0]);
        check_bit("sck idle", 1'b0, spi_sck_o);
        finish_test();
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        seed           = 58458;
        tests_passed   = 0;
        tests_failed   = 0;
        test_errors    = 0;
        rst_i          = 1'b1;
        psel_i         = 1'b0;
        penable_i      = 1'b0;
        pwrite_i       = 1'b0;
        paddr_i        = '0;
        pwdata_i       = '0;
        irq_i          = '0;
        internal_led_i = '0;
        repeat (4) @(negedge clk_i);
        rst_i = 1'b0;
        reset_state();
        id_and_unmapped();
        register_readback();
        interrupt_flow();
        led_register();
        led_scanner();
        spi_loopback();
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- surf_ctrl.f
surf_ctrl_pkg.sv
surf_ctrl_regs.sv
surf_ctrl_spi_master.sv
surf_ctrl_led_charlie.sv
surf_ctrl_top.sv
tb_surf_ctrl.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_surf_ctrl
FILELIST   := surf_ctrl.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
